// ==== common/noc_pkg.sv ====
package noc_pkg;

  typedef logic [33:0] flit_t;
  typedef logic [31:0] payload_t;
  typedef logic [2:0]  coord_t;
  typedef logic [7:0]  tag_t;
  typedef logic [7:0]  burst_len_t;

  typedef enum logic [2:0] {
    pkt_read               = 3'd0,
    pkt_write              = 3'd1,
    pkt_posted_write       = 3'd2,
    pkt_response           = 3'd3,
    pkt_response_with_data = 3'd4
  } packet_type_t;

  // Flit is {head, tail, payload}.
  function automatic logic flit_head(flit_t f);
    return f[33];
  endfunction

  function automatic logic flit_tail(flit_t f);
    return f[32];
  endfunction

  function automatic payload_t flit_payload(flit_t f);
    return f[31:0];
  endfunction

  function automatic flit_t make_flit(logic head, logic tail, payload_t payload);
    return {head, tail, payload};
  endfunction

  function automatic packet_type_t hdr_type(payload_t p);
    return packet_type_t'(p[2:0]);
  endfunction

  function automatic coord_t hdr_dst_x(payload_t p);
    return p[5:3];
  endfunction

  function automatic coord_t hdr_dst_y(payload_t p);
    return p[8:6];
  endfunction

  function automatic coord_t hdr_src_x(payload_t p);
    return p[11:9];
  endfunction

  function automatic coord_t hdr_src_y(payload_t p);
    return p[14:12];
  endfunction

  function automatic tag_t hdr_tag(payload_t p);
    return p[22:15];
  endfunction

  function automatic burst_len_t hdr_burst_len(payload_t p);
    return p[30:23];
  endfunction

  function automatic logic hdr_status(payload_t p);
    return p[31];  // Decode error.
  endfunction

  function automatic payload_t build_header(
    packet_type_t pkt_type,
    coord_t       dst_x,
    coord_t       dst_y,
    coord_t       src_x,
    coord_t       src_y,
    tag_t         tag,
    burst_len_t   burst_len,
    logic         status
  );
    return {status, burst_len, tag, src_y, src_x, dst_y, dst_x, pkt_type};
  endfunction

  function automatic logic is_non_posted(packet_type_t pkt_type);
    return (pkt_type == pkt_read) || (pkt_type == pkt_write);
  endfunction

endpackage

// ==== error_checker/flit_route_decode.sv ====
`timescale 1ns/100ps

module flit_route_decode import noc_pkg::*; #(
  parameter int SIZE_X = 4,
  parameter int SIZE_Y = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  flit_t in_flit,
  output logic  in_ready,
  input  logic  err_busy,
  output logic  norm_valid,
  output flit_t norm_flit,
  input  logic  norm_ready,
  output logic  err_valid,
  output flit_t err_flit,
  input  logic  err_ready
);

  typedef enum logic {
    route_normal,
    route_error
  } route_t;

  route_t   route_q;
  route_t   route_sel;
  payload_t in_payload;
  logic     pkt_open;
  logic     start_pkt;
  logic     bad_dest;
  logic     hold_head;
  logic     in_xfer;

  assign in_payload = flit_payload(in_flit);

  assign bad_dest = (int'(hdr_dst_x(in_payload)) >= SIZE_X) ||
                    (int'(hdr_dst_y(in_payload)) >= SIZE_Y);

  assign start_pkt = !pkt_open && flit_head(in_flit);

  always_comb begin
    route_sel = route_q;
    if (start_pkt) begin
      route_sel = bad_dest ? route_error : route_normal;
    end
  end

  assign hold_head = start_pkt && err_busy;  // Response still in flight.

  assign norm_valid = in_valid && !hold_head && (route_sel == route_normal);
  assign err_valid  = in_valid && !hold_head && (route_sel == route_error);
  assign norm_flit  = in_flit;
  assign err_flit   = in_flit;

  assign in_ready = !hold_head &&
                    ((route_sel == route_normal) ? norm_ready : err_ready);
  assign in_xfer  = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_q  <= route_normal;
      pkt_open <= 1'b0;
    end else if (in_xfer) begin
      if (start_pkt) begin
        route_q <= route_sel;  // Held for the rest of the packet.
      end
      pkt_open <= !flit_tail(in_flit);
    end
  end

endmodule

// ==== error_checker/error_responder.sv ====
`timescale 1ns/100ps

module error_responder import noc_pkg::*; #(
  parameter payload_t ERROR_DATA = 32'hdead_beef
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  err_valid,
  input  flit_t err_flit,
  output logic  err_ready,
  output logic  err_busy,
  output logic  rsp_valid,
  output flit_t rsp_flit,
  input  logic  rsp_ready
);

  typedef enum logic [1:0] {
    idle,
    drain,
    send_head,
    send_data
  } state_t;

  state_t       state_q;
  state_t       state_d;
  payload_t     err_payload;
  payload_t     rsp_header;
  packet_type_t cur_type;
  packet_type_t req_type;
  coord_t       req_dst_x;
  coord_t       req_dst_y;
  coord_t       req_src_x;
  coord_t       req_src_y;
  tag_t         req_tag;
  burst_len_t   req_len;
  burst_len_t   data_cnt;
  logic         is_read;
  logic         has_data;
  logic         err_xfer;
  logic         rsp_xfer;

  assign err_payload = flit_payload(err_flit);

  assign err_ready = (state_q == idle) || (state_q == drain);
  assign err_xfer  = err_valid && err_ready;
  assign rsp_valid = (state_q == send_head) || (state_q == send_data);
  assign rsp_xfer  = rsp_valid && rsp_ready;

  // In idle the header is still on the input.
  assign cur_type = (state_q == idle) ? hdr_type(err_payload) : req_type;
  assign err_busy = (state_q != idle) && is_non_posted(req_type);

  assign is_read  = (req_type == pkt_read);
  assign has_data = is_read && (req_len != 8'd0);

  // Source and destination swapped.
  assign rsp_header = build_header(
    is_read ? pkt_response_with_data : pkt_response,
    req_src_x,
    req_src_y,
    req_dst_x,
    req_dst_y,
    req_tag,
    is_read ? req_len : 8'd0,
    1'b1
  );

  assign rsp_flit = (state_q == send_data) ?
                    make_flit(1'b0, data_cnt == 8'd1, ERROR_DATA) :
                    make_flit(1'b1, !has_data, rsp_header);

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle, drain: begin
        if (err_xfer && flit_tail(err_flit)) begin
          state_d = is_non_posted(cur_type) ? send_head : idle;
        end else if (err_xfer) begin
          state_d = drain;
        end
      end
      send_head: begin
        if (rsp_xfer) begin
          state_d = has_data ? send_data : idle;
        end
      end
      send_data: begin
        if (rsp_xfer && (data_cnt == 8'd1)) begin
          state_d = idle;
        end
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= idle;
      data_cnt <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == send_head) begin
        data_cnt <= req_len;
      end else if ((state_q == send_data) && rsp_xfer) begin
        data_cnt <= data_cnt - 8'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (err_xfer && (state_q == idle)) begin
      req_type  <= hdr_type(err_payload);
      req_dst_x <= hdr_dst_x(err_payload);
      req_dst_y <= hdr_dst_y(err_payload);
      req_src_x <= hdr_src_x(err_payload);
      req_src_y <= hdr_src_y(err_payload);
      req_tag   <= hdr_tag(err_payload);
      req_len   <= hdr_burst_len(err_payload);
    end
  end

endmodule

// ==== error_checker/flit_merge_slice.sv ====
`timescale 1ns/100ps

module flit_merge_slice import noc_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  norm_valid,
  input  flit_t norm_flit,
  output logic  norm_ready,
  input  logic  rsp_valid,
  input  flit_t rsp_flit,
  output logic  rsp_ready,
  output logic  out_valid,
  output flit_t out_flit,
  input  logic  out_ready
);

  typedef enum logic [1:0] {
    free,
    lock_norm,
    lock_rsp
  } lock_t;

  lock_t lock_q;
  logic  take_rsp;
  logic  load_ok;
  logic  sel_valid;
  flit_t sel_flit;
  logic  accept;
  logic  out_valid_q;
  flit_t out_flit_q;

  // Response wins when both could start a packet.
  assign take_rsp = (lock_q == lock_rsp) || ((lock_q == free) && rsp_valid);

  assign sel_valid = take_rsp ? rsp_valid : norm_valid;
  assign sel_flit  = take_rsp ? rsp_flit : norm_flit;

  assign load_ok = !out_valid_q || out_ready;
  assign accept  = sel_valid && load_ok;

  assign rsp_ready  = load_ok && take_rsp;
  assign norm_ready = load_ok && !take_rsp;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock_q <= free;
    end else if (accept) begin
      if (flit_tail(sel_flit)) begin
        lock_q <= free;
      end else if (flit_head(sel_flit)) begin
        lock_q <= take_rsp ? lock_rsp : lock_norm;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (load_ok) begin
      out_valid_q <= sel_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_flit_q <= sel_flit;
    end
  end

  assign out_valid = out_valid_q;
  assign out_flit  = out_flit_q;

endmodule

// ==== error_checker/noc_error_checker.sv ====
`timescale 1ns/100ps

module noc_error_checker import noc_pkg::*; #(
  parameter int       SIZE_X     = 4,
  parameter int       SIZE_Y     = 4,
  parameter payload_t ERROR_DATA = 32'hdead_beef
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  flit_t in_flit,
  output logic  in_ready,
  output logic  out_valid,
  output flit_t out_flit,
  input  logic  out_ready
);

  logic  norm_valid;
  flit_t norm_flit;
  logic  norm_ready;
  logic  err_valid;
  flit_t err_flit;
  logic  err_ready;
  logic  err_busy;
  logic  rsp_valid;
  flit_t rsp_flit;
  logic  rsp_ready;

  flit_route_decode #(
    .SIZE_X (SIZE_X),
    .SIZE_Y (SIZE_Y)
  ) u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_flit    (in_flit),
    .in_ready   (in_ready),
    .err_busy   (err_busy),
    .norm_valid (norm_valid),
    .norm_flit  (norm_flit),
    .norm_ready (norm_ready),
    .err_valid  (err_valid),
    .err_flit   (err_flit),
    .err_ready  (err_ready)
  );

  error_responder #(
    .ERROR_DATA (ERROR_DATA)
  ) u_responder (
    .clk       (clk),
    .rst_n     (rst_n),
    .err_valid (err_valid),
    .err_flit  (err_flit),
    .err_ready (err_ready),
    .err_busy  (err_busy),
    .rsp_valid (rsp_valid),
    .rsp_flit  (rsp_flit),
    .rsp_ready (rsp_ready)
  );

  flit_merge_slice u_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .norm_valid (norm_valid),
    .norm_flit  (norm_flit),
    .norm_ready (norm_ready),
    .rsp_valid  (rsp_valid),
    .rsp_flit   (rsp_flit),
    .rsp_ready  (rsp_ready),
    .out_valid  (out_valid),
    .out_flit   (out_flit),
    .out_ready  (out_ready)
  );

endmodule

// ==== tb/tb_packet_table.svh ====
`ifndef TB_PACKET_TABLE_SVH
`define TB_PACKET_TABLE_SVH

  // Columns are type, dst x, dst y, src x, src y, tag, burst length and expected outcome.
  // Outcome on out is the packet itself, a read or write error response, or nothing.

  localparam logic [1:0] OUT_PASS   = 2'd0;
  localparam logic [1:0] OUT_RD_ERR = 2'd1;
  localparam logic [1:0] OUT_WR_ERR = 2'd2;
  localparam logic [1:0] OUT_DROP   = 2'd3;

  typedef struct packed {
    packet_type_t pkt_type;
    coord_t       dst_x;
    coord_t       dst_y;
    coord_t       src_x;
    coord_t       src_y;
    tag_t         tag;
    burst_len_t   burst_len;
    logic [1:0]   expect_kind;
  } row_t;

  localparam int NUM_ROWS = 22;

  localparam row_t PACKET_TABLE [NUM_ROWS] = '{
    '{pkt_read,               3'd1, 3'd2, 3'd0, 3'd0, 8'h01, 8'd4, OUT_PASS},
    '{pkt_write,              3'd3, 3'd3, 3'd1, 3'd1, 8'h02, 8'd3, OUT_PASS},   // Mesh corner.
    '{pkt_read,               3'd3, 3'd0, 3'd2, 3'd1, 8'h03, 8'd1, OUT_PASS},
    '{pkt_write,              3'd0, 3'd3, 3'd2, 3'd2, 8'h04, 8'd0, OUT_PASS},
    '{pkt_read,               3'd4, 3'd1, 3'd1, 3'd2, 8'h10, 8'd4, OUT_RD_ERR}, // X just outside.
    '{pkt_read,               3'd2, 3'd5, 3'd0, 3'd3, 8'h11, 8'd2, OUT_RD_ERR},
    '{pkt_write,              3'd7, 3'd0, 3'd3, 3'd1, 8'h12, 8'd3, OUT_WR_ERR},
    '{pkt_write,              3'd1, 3'd4, 3'd2, 3'd0, 8'h13, 8'd0, OUT_WR_ERR},
    '{pkt_posted_write,       3'd5, 3'd5, 3'd0, 3'd1, 8'h14, 8'd2, OUT_DROP},
    '{pkt_write,              3'd2, 3'd2, 3'd3, 3'd3, 8'h15, 8'd2, OUT_PASS},
    '{pkt_response,           3'd6, 3'd1, 3'd1, 3'd1, 8'h16, 8'd0, OUT_DROP},
    '{pkt_response_with_data, 3'd0, 3'd7, 3'd2, 3'd3, 8'h17, 8'd3, OUT_DROP},
    '{pkt_read,               3'd1, 3'd1, 3'd3, 3'd2, 8'h18, 8'd5, OUT_PASS},
    '{pkt_read,               3'd7, 3'd7, 3'd3, 3'd3, 8'h19, 8'd8, OUT_RD_ERR},
    '{pkt_write,              3'd4, 3'd4, 3'd0, 3'd0, 8'h1a, 8'd5, OUT_WR_ERR},
    '{pkt_posted_write,       3'd3, 3'd1, 3'd1, 3'd3, 8'h1b, 8'd4, OUT_PASS},
    '{pkt_response_with_data, 3'd2, 3'd0, 3'd3, 3'd0, 8'h1c, 8'd2, OUT_PASS},
    '{pkt_read,               3'd0, 3'd4, 3'd1, 3'd0, 8'h1d, 8'd1, OUT_RD_ERR},
    '{pkt_response,           3'd3, 3'd2, 3'd2, 3'd1, 8'h1e, 8'd0, OUT_PASS},
    '{pkt_write,              3'd1, 3'd0, 3'd0, 3'd2, 8'h1f, 8'd6, OUT_PASS},
    '{pkt_posted_write,       3'd3, 3'd4, 3'd2, 3'd2, 8'h20, 8'd1, OUT_DROP},
    '{pkt_read,               3'd2, 3'd3, 3'd1, 3'd1, 8'h21, 8'd3, OUT_PASS}
  };

`endif

// ==== tb/tb_noc_error_checker.sv ====
`timescale 1ns/100ps

module tb_noc_error_checker import noc_pkg::*; ();

  localparam int       SIZE_X     = 4;
  localparam int       SIZE_Y     = 4;
  localparam payload_t ERROR_DATA = 32'hdead_beef;

  `include "tb_packet_table.svh"

  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 200;
  localparam int DRAIN_LIMIT    = 64;

  logic  clk;
  logic  rst_n;
  logic  in_valid;
  flit_t in_flit;
  logic  in_ready;
  logic  out_valid;
  flit_t out_flit;
  logic  out_ready;

  flit_t       expected_q[$];
  flit_t       pkt_flits[$];
  int          error_count = 0;
  int          flit_count = 0;
  logic [31:0] data_rng;
  logic [31:0] ready_rng;

  noc_error_checker uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Type in the low bits, status on top.
  function automatic payload_t pack_header(packet_type_t pkt_type, coord_t dx, coord_t dy,
                                           coord_t sx, coord_t sy, tag_t tag,
                                           burst_len_t len, logic status);
    return {status, len, tag, sy, sx, dy, dx, pkt_type};
  endfunction

  function automatic logic [1:0] outcome_of(row_t row);
    logic bad;
    bad = (int'(row.dst_x) >= SIZE_X) || (int'(row.dst_y) >= SIZE_Y);
    if (!bad) begin
      return OUT_PASS;
    end
    if (row.pkt_type == pkt_read) begin
      return OUT_RD_ERR;
    end
    if (row.pkt_type == pkt_write) begin
      return OUT_WR_ERR;
    end
    return OUT_DROP;
  endfunction

  function automatic int data_flits_of(row_t row);
    if ((row.pkt_type == pkt_write) || (row.pkt_type == pkt_posted_write) ||
        (row.pkt_type == pkt_response_with_data)) begin
      return int'(row.burst_len);
    end
    return 0;  // Reads and plain responses are head only.
  endfunction

  task automatic build_packet(input row_t row);
    int       n_data;
    payload_t hdr;
    n_data = data_flits_of(row);
    hdr = pack_header(row.pkt_type, row.dst_x, row.dst_y, row.src_x, row.src_y,
                      row.tag, row.burst_len, 1'b0);
    pkt_flits.delete();
    pkt_flits.push_back({1'b1, n_data == 0, hdr});
    for (int i = 0; i < n_data; i++) begin
      data_rng = xorshift32(data_rng);
      pkt_flits.push_back({1'b0, i == n_data - 1, data_rng});
    end
  endtask

  task automatic model_packet(input row_t row, input int idx);
    logic [1:0] kind;
    payload_t   rsp_hdr;
    int         len;
    kind = outcome_of(row);
    len  = int'(row.burst_len);
    if (kind != row.expect_kind) begin
      $display("Table row %0d lists outcome %0d, but the destination rules give %0d",
               idx, row.expect_kind, kind);
      error_count++;
    end
    case (kind)
      OUT_PASS: begin
        foreach (pkt_flits[i]) begin
          expected_q.push_back(pkt_flits[i]);
        end
      end
      OUT_RD_ERR: begin
        rsp_hdr = pack_header(pkt_response_with_data, row.src_x, row.src_y, row.dst_x,
                              row.dst_y, row.tag, row.burst_len, 1'b1);
        expected_q.push_back({1'b1, len == 0, rsp_hdr});
        for (int i = 0; i < len; i++) begin
          expected_q.push_back({1'b0, i == len - 1, ERROR_DATA});
        end
      end
      OUT_WR_ERR: begin
        rsp_hdr = pack_header(pkt_response, row.src_x, row.src_y, row.dst_x,
                              row.dst_y, row.tag, 8'd0, 1'b1);
        expected_q.push_back({1'b1, 1'b1, rsp_hdr});
      end
      default: begin
      end
    endcase
  endtask

  // Starts and ends on a rising edge.
  task automatic send_packet();
    foreach (pkt_flits[i]) begin
      in_valid <= 1'b1;
      in_flit  <= pkt_flits[i];
      @(negedge clk);
      while (!in_ready) begin
        @(negedge clk);
      end
      @(posedge clk);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    ready_rng = 32'hb0a6;
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      ready_rng = xorshift32(ready_rng);
      out_ready <= (ready_rng % 32'd3) != 32'd0;  // Low about a third of the time.
    end
  end

  always @(negedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (expected_q.size() == 0) begin
        $display("Flit %h left on out when no flit was expected", out_flit);
        error_count++;
      end else begin
        if (out_flit !== expected_q[0]) begin
          $display("** Error: out_flit at flit %0d expected %h actual %h",
                   flit_count, expected_q[0], out_flit);
          error_count++;
        end
        void'(expected_q.pop_front());
        flit_count++;
      end
    end
  end

  // Both reset cycles and the first cycle after.
  initial begin
    repeat (3) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        $display("** Error: out_valid around reset expected %h actual %h", 1'b0, out_valid);
        error_count++;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d flits still expected on out",
             TIMEOUT_CYCLES, expected_q.size());
    $display("Errors: %0d, flits checked: %0d", error_count + 1, flit_count);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_flit  = '0;
    data_rng = 32'hb0a6;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int r = 0; r < NUM_ROWS; r++) begin
      build_packet(PACKET_TABLE[r]);
      model_packet(PACKET_TABLE[r], r);
      send_packet();
    end
    in_valid <= 1'b0;
    in_flit  <= '0;
    for (int c = 0; (c < DRAIN_LIMIT) && (expected_q.size() != 0); c++) begin
      @(posedge clk);
    end
    repeat (8) @(posedge clk);  // Room for stray flits.
    if (expected_q.size() != 0) begin
      $display("%0d expected flits never appeared on out", expected_q.size());
      error_count++;
    end
    $display("Errors: %0d, flits checked: %0d", error_count, flit_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+tb
common/noc_pkg.sv
error_checker/flit_route_decode.sv
error_checker/error_responder.sv
error_checker/flit_merge_slice.sv
error_checker/noc_error_checker.sv
tb/tb_noc_error_checker.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_noc_error_checker
SRCS := common/noc_pkg.sv $(wildcard error_checker/*.sv) $(wildcard tb/*.sv tb/*.svh)

.PHONY: all run clean

all: run

$(SIM): build.f $(SRCS)
	verilator --binary --timing -f build.f --top-module tb_noc_error_checker -Mdir obj_dir

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
